//--- logic/rv32i_isa_pkg.sv
package rv32i_isa_pkg;

    // Datapath and instruction width
    parameter int XLEN = 32;

    // Base opcode field, bits [6:0]
    typedef logic [6:0] opcode_t;

    // Major opcodes used by the decoder
    parameter opcode_t OP_LUI    = 7'b0110111;
    parameter opcode_t OP_AUIPC  = 7'b0010111;
    parameter opcode_t OP_JAL    = 7'b1101111;
    parameter opcode_t OP_JALR   = 7'b1100111;
    parameter opcode_t OP_BRANCH = 7'b1100011;
    parameter opcode_t OP_LOAD   = 7'b0000011;
    parameter opcode_t OP_STORE  = 7'b0100011;
    parameter opcode_t OP_IMM    = 7'b0010011; // Register-immediate ALU ops
    parameter opcode_t OP_REG    = 7'b0110011; // Register-register ALU ops

    // Bit positions of the fixed instruction fields
    parameter int OPCODE_LSB = 0;
    parameter int OPCODE_W   = 7;
    parameter int RD_LSB     = 7;
    parameter int FUNCT3_LSB = 12;
    parameter int RS1_LSB    = 15;
    parameter int RS2_LSB    = 20;
    parameter int FUNCT7_LSB = 25;
    parameter int SHAMT_W    = 5;  // Shift amount width on RV32

    // funct3 codes within OP_IMM
    parameter logic [2:0] FUNCT3_ADDI      = 3'b000;
    parameter logic [2:0] FUNCT3_SLLI      = 3'b001;
    parameter logic [2:0] FUNCT3_SLTI      = 3'b010;
    parameter logic [2:0] FUNCT3_SLTIU     = 3'b011;
    parameter logic [2:0] FUNCT3_XORI      = 3'b100;
    parameter logic [2:0] FUNCT3_SRLI_SRAI = 3'b101; // funct7 tells them apart
    parameter logic [2:0] FUNCT3_ORI       = 3'b110;
    parameter logic [2:0] FUNCT3_ANDI      = 3'b111;

    // JALR only defines funct3 000
    parameter logic [2:0] FUNCT3_JALR = 3'b000;

    // funct7 values legal on shift-immediates
    parameter logic [6:0] FUNCT7_BASE = 7'b0000000; // SLLI, SRLI
    parameter logic [6:0] FUNCT7_ALT  = 7'b0100000; // SRAI

endpackage

//--- logic/decode_types_pkg.sv
package decode_types_pkg;

    // Widest register index any build uses, RV32I
    parameter int REG_WIDTH_MAX = 5;

    // Fetched word as it enters the decode stage
    typedef struct packed {
        logic [rv32i_isa_pkg::XLEN-1:0] inst; // Raw instruction
        logic [rv32i_isa_pkg::XLEN-1:0] pc;   // Its program counter
    } fetch_word_t;

    // Decoded bundle handed to execute
    typedef struct packed {
        logic [rv32i_isa_pkg::XLEN-1:0] pc;
        rv32i_isa_pkg::opcode_t         opcode;
        logic [REG_WIDTH_MAX-1:0]       rd;       // Zero-extended on narrow builds
        logic [rv32i_isa_pkg::XLEN-1:0] rs1_data;
        logic [rv32i_isa_pkg::XLEN-1:0] rs2_data;
        logic [rv32i_isa_pkg::XLEN-1:0] imm;      // Already sign/zero extended
        logic                           is_load;
        logic                           is_alu;
    } decoded_t;

endpackage

//--- logic/pipe_stage.sv
`timescale 1ns/10ps

module pipe_stage
#(
    parameter type T_PAYLOAD = logic [31:0])
 (
    input  logic     i_clk,
    input  logic     i_rst_n,  // Synchronous, active low
    input  logic     i_valid,  // Payload at i_data is live
    input  T_PAYLOAD i_data,
    input  logic     i_stall,  // Hold everything
    input  logic     i_flush,  // Drop the held entry
    output logic     o_valid,
    output T_PAYLOAD o_data);

    logic     valid_q;
    T_PAYLOAD data_q;

    // Valid tag, flush beats stall
    always_ff @(posedge i_clk) begin
        if (!i_rst_n || i_flush) begin
            valid_q <= 1'b0;
        end else if (!i_stall) begin
            valid_q <= i_valid;
        end
    end

    // Payload only moves on a live, unstalled cycle
    always_ff @(posedge i_clk) begin
        if (!i_stall && i_valid) begin
            data_q <= i_data;
        end
    end

    assign o_valid = valid_q;
    assign o_data  = data_q;

endmodule

//--- logic/rv32i_decoder.sv
`timescale 1ns/10ps

module rv32i_decoder
#(
    parameter int REG_WIDTH = 5)
 (
    input  logic [rv32i_isa_pkg::XLEN-1:0] i_inst,    // Instruction word
    output rv32i_isa_pkg::opcode_t         o_opcode,  // Major opcode
    output logic [REG_WIDTH-1:0]           o_rs1,     // Source register 1
    output logic [REG_WIDTH-1:0]           o_rs2,     // Source register 2
    output logic [REG_WIDTH-1:0]           o_rd,      // Destination register
    output logic [rv32i_isa_pkg::XLEN-1:0] o_imm,     // Extended immediate
    output logic                           o_is_load, // LOAD class
    output logic                           o_is_alu); // OP or OP-IMM class

    import rv32i_isa_pkg::*;

    opcode_t           opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_shamt;

    // Fixed fields
    assign opcode = i_inst[OPCODE_LSB +: OPCODE_W];
    assign funct3 = i_inst[FUNCT3_LSB +: 3];
    assign funct7 = i_inst[FUNCT7_LSB +: 7];

    // One candidate immediate per format
    assign imm_u = {i_inst[31:12], 12'b0};
    assign imm_j = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
    assign imm_b = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
    assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
    assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
    assign imm_shamt = {{(XLEN-SHAMT_W){1'b0}}, i_inst[RS2_LSB +: SHAMT_W]}; // Never negative

    // Pick the immediate by format
    always_comb begin
        unique case (opcode)
            OP_LUI,
            OP_AUIPC:  o_imm = imm_u;
            OP_JAL:    o_imm = imm_j;
            OP_BRANCH: o_imm = imm_b;
            OP_LOAD:   o_imm = imm_i;
            OP_STORE:  o_imm = imm_s;

            OP_JALR: begin
                // Other funct3 values are not defined for JALR
                o_imm = (funct3 == FUNCT3_JALR) ? imm_i : '0;
            end

            OP_IMM: begin
                unique case (funct3)
                    FUNCT3_SLLI:
                        o_imm = (funct7 == FUNCT7_BASE) ? imm_shamt : '0;
                    FUNCT3_SRLI_SRAI:
                        o_imm = (funct7 == FUNCT7_BASE || funct7 == FUNCT7_ALT) ?
                                imm_shamt : '0;
                    FUNCT3_ADDI,
                    FUNCT3_SLTI,
                    FUNCT3_SLTIU,
                    FUNCT3_XORI,
                    FUNCT3_ORI,
                    FUNCT3_ANDI:
                        o_imm = imm_i;
                    default:
                        o_imm = '0;
                endcase
            end

            default:   o_imm = '0; // Unknown encodings, also OP_REG
        endcase
    end

    // Register indices, truncated on narrow builds
    assign o_rs1 = i_inst[RS1_LSB +: REG_WIDTH];
    assign o_rs2 = i_inst[RS2_LSB +: REG_WIDTH];
    assign o_rd  = i_inst[RD_LSB +: REG_WIDTH];

    // Class flags
    assign o_is_load = (opcode == OP_LOAD);
    assign o_is_alu  = (opcode == OP_REG) || (opcode == OP_IMM);

    assign o_opcode = opcode;

endmodule

//--- logic/reg_file.sv
`timescale 1ns/10ps

module reg_file
#(
    parameter int REG_WIDTH = 5)
 (
    input  logic                           i_clk,
    input  logic                           i_rst_n,    // Clears every register
    input  logic [REG_WIDTH-1:0]           i_rs1,      // Read port 1 index
    input  logic [REG_WIDTH-1:0]           i_rs2,      // Read port 2 index
    output logic [rv32i_isa_pkg::XLEN-1:0] o_rs1_data,
    output logic [rv32i_isa_pkg::XLEN-1:0] o_rs2_data,
    input  logic                           i_wb_en,    // Writeback strobe
    input  logic [REG_WIDTH-1:0]           i_wb_rd,    // Writeback index
    input  logic [rv32i_isa_pkg::XLEN-1:0] i_wb_data);

    import rv32i_isa_pkg::*;

    // 32 entries for RV32I, 16 for RV32E
    localparam int NUM_REGS = 1 << REG_WIDTH;

    logic [XLEN-1:0] regs [NUM_REGS];
    logic            wb_live;

    // x0 never takes a write
    assign wb_live = i_wb_en && (i_wb_rd != '0);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[i_wb_rd] <= i_wb_data;
        end
    end

    // Read port 1, zero register then bypass then array
    always_comb begin
        if (i_rs1 == '0)                      o_rs1_data = '0;
        else if (wb_live && i_wb_rd == i_rs1) o_rs1_data = i_wb_data; // Write-through
        else                                  o_rs1_data = regs[i_rs1];
    end

    // Read port 2, same rules
    always_comb begin
        if (i_rs2 == '0)                      o_rs2_data = '0;
        else if (wb_live && i_wb_rd == i_rs2) o_rs2_data = i_wb_data;
        else                                  o_rs2_data = regs[i_rs2];
    end

endmodule

//--- logic/decode_stage_top.sv
`timescale 1ns/10ps

module decode_stage_top
#(
    parameter int REG_WIDTH = 5)  // 4 gives an RV32E build
 (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    // Fetch side
    input  logic                           i_inst_valid, // One-cycle strobe
    input  logic [rv32i_isa_pkg::XLEN-1:0] i_inst,
    input  logic [rv32i_isa_pkg::XLEN-1:0] i_pc,
    // Pipeline control
    input  logic                           i_stall,      // Level, holds both stages
    input  logic                           i_flush,      // Pulse, kills both stages
    // Writeback port
    input  logic                           i_wb_en,
    input  logic [REG_WIDTH-1:0]           i_wb_rd,
    input  logic [rv32i_isa_pkg::XLEN-1:0] i_wb_data,
    // Execute side
    output logic                           o_valid,
    output logic [rv32i_isa_pkg::XLEN-1:0] o_pc,
    output rv32i_isa_pkg::opcode_t         o_opcode,
    output logic [REG_WIDTH-1:0]           o_rd,
    output logic [rv32i_isa_pkg::XLEN-1:0] o_rs1_data,
    output logic [rv32i_isa_pkg::XLEN-1:0] o_rs2_data,
    output logic [rv32i_isa_pkg::XLEN-1:0] o_imm,
    output logic                           o_is_load,
    output logic                           o_is_alu);

    import rv32i_isa_pkg::*;
    import decode_types_pkg::*;

    fetch_word_t            fetch_in;
    fetch_word_t            fetch_q;    // Registered fetch word
    logic                   fetch_valid;
    opcode_t                dec_opcode;
    logic [REG_WIDTH-1:0]   dec_rs1;
    logic [REG_WIDTH-1:0]   dec_rs2;
    logic [REG_WIDTH-1:0]   dec_rd;
    logic [XLEN-1:0]        dec_imm;
    logic                   dec_is_load;
    logic                   dec_is_alu;
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    decoded_t               decode_in;
    decoded_t               decode_q;   // Registered bundle

    // Input side
    assign fetch_in = '{inst: i_inst, pc: i_pc};

    pipe_stage #(
        .T_PAYLOAD (fetch_word_t))
    fetch_reg_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (i_inst_valid),
        .i_data  (fetch_in),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .o_valid (fetch_valid),
        .o_data  (fetch_q));

    // Decode and operand read, all combinational off fetch_q
    rv32i_decoder #(
        .REG_WIDTH (REG_WIDTH))
    decoder_i (
        .i_inst    (fetch_q.inst),
        .o_opcode  (dec_opcode),
        .o_rs1     (dec_rs1),
        .o_rs2     (dec_rs2),
        .o_rd      (dec_rd),
        .o_imm     (dec_imm),
        .o_is_load (dec_is_load),
        .o_is_alu  (dec_is_alu));

    reg_file #(
        .REG_WIDTH (REG_WIDTH))
    reg_file_i (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_rs1      (dec_rs1),
        .i_rs2      (dec_rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_wb_en    (i_wb_en),
        .i_wb_rd    (i_wb_rd),
        .i_wb_data  (i_wb_data));

    // Bundle for execute, rd widened to the struct field
    assign decode_in = '{pc:       fetch_q.pc,
                         opcode:   dec_opcode,
                         rd:       REG_WIDTH_MAX'(dec_rd),
                         rs1_data: rs1_data,
                         rs2_data: rs2_data,
                         imm:      dec_imm,
                         is_load:  dec_is_load,
                         is_alu:   dec_is_alu};

    // Output side
    pipe_stage #(
        .T_PAYLOAD (decoded_t))
    decode_reg_i (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (fetch_valid),
        .i_data  (decode_in),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .o_valid (o_valid),
        .o_data  (decode_q));

    assign o_pc       = decode_q.pc;
    assign o_opcode   = decode_q.opcode;
    assign o_rd       = decode_q.rd[REG_WIDTH-1:0]; // Drop the zero padding
    assign o_rs1_data = decode_q.rs1_data;
    assign o_rs2_data = decode_q.rs2_data;
    assign o_imm      = decode_q.imm;
    assign o_is_load  = decode_q.is_load;
    assign o_is_alu   = decode_q.is_alu;

endmodule

//--- tests/decode_stage_tb.sv
`timescale 1ns/10ps

module decode_stage_tb;

    import rv32i_isa_pkg::*;
    import decode_types_pkg::*;

    localparam int REG_WIDTH    = 5;
    localparam int NUM_REGS     = 1 << REG_WIDTH;
    localparam int CLK_HALF_NS  = 4;    // 8 ns period
    localparam int RESET_CYCLES = 8;
    localparam int N_DIRECTED   = 48;   // Directed steps including idle cycles
    localparam int N_BURST      = 16;
    localparam int N_RANDOM     = 400;
    localparam int N_TAIL       = 12;   // Instructions after the second reset
    localparam int N_TOTAL      = N_DIRECTED + N_BURST + N_RANDOM + N_TAIL;
    localparam int TIMEOUT_NS   = N_TOTAL * 8 * 4 + 2 * RESET_CYCLES * 8;
    localparam logic [31:0] RAND_SEED = 32'hf9c0;

    // One word per immediate format plus negative and illegal corners
    localparam int N_WORDS = 15;
    localparam logic [31:0] DIRECTED_WORDS [N_WORDS] = '{
        32'h800000b7,   // LUI with the top bit set
        32'h12345017,   // AUIPC
        32'hfe5ff06f,   // JAL with a negative offset
        32'hfe208ee3,   // BEQ with a negative offset
        32'hfff0a083,   // LW at offset -1
        32'hfe112e23,   // SW with a negative offset
        32'h00008067,   // JALR with funct3 000
        32'h00109067,   // JALR with funct3 001
        32'hfff00093,   // ADDI -1
        32'h01f09093,   // SLLI by 31
        32'h4020d093,   // SRAI by 2
        32'h2020d093,   // Shift right with a bad funct7
        32'h02209093,   // SLLI with a bad funct7
        32'h002081b3,   // ADD
        32'h0000007f    // No such opcode
    };

    logic                   i_clk = 1'b0;
    logic                   i_rst_n;
    logic                   i_inst_valid;
    logic [XLEN-1:0]        i_inst;
    logic [XLEN-1:0]        i_pc;
    logic                   i_stall;
    logic                   i_flush;
    logic                   i_wb_en;
    logic [REG_WIDTH-1:0]   i_wb_rd;
    logic [XLEN-1:0]        i_wb_data;
    logic                   o_valid;
    logic [XLEN-1:0]        o_pc;
    opcode_t                o_opcode;
    logic [REG_WIDTH-1:0]   o_rd;
    logic [XLEN-1:0]        o_rs1_data;
    logic [XLEN-1:0]        o_rs2_data;
    logic [XLEN-1:0]        o_imm;
    logic                   o_is_load;
    logic                   o_is_alu;

    // Model state
    logic [XLEN-1:0]        model_regs [NUM_REGS];
    logic                   fm_valid;       // Input stage holds a live word
    logic [XLEN-1:0]        fm_inst;
    logic [XLEN-1:0]        fm_pc;
    decoded_t               exp_q [$];      // Entry now in the output stage
    logic [XLEN-1:0]        next_pc;
    int unsigned            seed_ret;

    decode_stage_top #(
        .REG_WIDTH (REG_WIDTH))
    dut_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_inst_valid (i_inst_valid),
        .i_inst       (i_inst),
        .i_pc         (i_pc),
        .i_stall      (i_stall),
        .i_flush      (i_flush),
        .i_wb_en      (i_wb_en),
        .i_wb_rd      (i_wb_rd),
        .i_wb_data    (i_wb_data),
        .o_valid      (o_valid),
        .o_pc         (o_pc),
        .o_opcode     (o_opcode),
        .o_rd         (o_rd),
        .o_rs1_data   (o_rs1_data),
        .o_rs2_data   (o_rs2_data),
        .o_imm        (o_imm),
        .o_is_load    (o_is_load),
        .o_is_alu     (o_is_alu));

    always #(CLK_HALF_NS) i_clk = ~i_clk;

    // Register read as the decode stage sees it with x0 and write-through first
    function automatic logic [XLEN-1:0] read_model(input logic [XLEN-1:0] regs [NUM_REGS],
                                                   input logic [REG_WIDTH-1:0] idx,
                                                   input logic wb_en,
                                                   input logic [REG_WIDTH-1:0] wb_rd,
                                                   input logic [XLEN-1:0] wb_data);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    // Expected bundle for one instruction
    function automatic decoded_t decode_ref(input logic [XLEN-1:0] inst,
                                            input logic [XLEN-1:0] pc,
                                            input logic [XLEN-1:0] regs [NUM_REGS],
                                            input logic wb_en,
                                            input logic [REG_WIDTH-1:0] wb_rd,
                                            input logic [XLEN-1:0] wb_data);
        decoded_t   d;
        opcode_t    op;
        logic [2:0] f3;
        logic [6:0] f7;
        op         = inst[6:0];
        f3         = inst[14:12];
        f7         = inst[31:25];
        d          = '0;
        d.pc       = pc;
        d.opcode   = op;
        d.rd       = inst[11:7];
        d.rs1_data = read_model(regs, inst[19:15], wb_en, wb_rd, wb_data);
        d.rs2_data = read_model(regs, inst[24:20], wb_en, wb_rd, wb_data);
        case (op)
            OP_LUI, OP_AUIPC: d.imm = inst & 32'hffff_f000;
            OP_JAL:    d.imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            OP_BRANCH: d.imm = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            OP_LOAD:   d.imm = 32'($signed(inst[31:20]));
            OP_STORE:  d.imm = 32'($signed({inst[31:25], inst[11:7]}));
            OP_JALR:   d.imm = (f3 == 3'b000) ? 32'($signed(inst[31:20])) : 32'h0;
            OP_IMM: begin
                if (f3 == 3'b001) begin
                    d.imm = (f7 == 7'h00) ? {27'h0, inst[24:20]} : 32'h0;   // SLLI
                end else if (f3 == 3'b101) begin
                    d.imm = (f7 == 7'h00 || f7 == 7'h20) ? {27'h0, inst[24:20]} : 32'h0;
                end else begin
                    d.imm = 32'($signed(inst[31:20]));
                end
            end
            default:   d.imm = 32'h0;   // R-type and unknown
        endcase
        d.is_load = (op == OP_LOAD);
        d.is_alu  = (op == OP_REG) || (op == OP_IMM);
        return d;
    endfunction

    function automatic bit is_known_opcode(input opcode_t op);
        return op == OP_LUI || op == OP_AUIPC || op == OP_JAL || op == OP_JALR ||
               op == OP_BRANCH || op == OP_LOAD || op == OP_STORE || op == OP_IMM ||
               op == OP_REG;
    endfunction

    // Random word with its opcode picked evenly from nine classes or an illegal value
    function automatic logic [XLEN-1:0] random_inst();
        logic [XLEN-1:0] w;
        int unsigned     cls;
        w   = $urandom();
        cls = $urandom() % 10;
        case (cls)
            0: w[6:0] = OP_LUI;
            1: w[6:0] = OP_AUIPC;
            2: w[6:0] = OP_JAL;
            3: begin
                w[6:0] = OP_JALR;
                if (($urandom() % 2) == 0) begin
                    w[14:12] = 3'b000;  // Legal JALR half the time
                end
            end
            4: w[6:0] = OP_BRANCH;
            5: w[6:0] = OP_LOAD;
            6: w[6:0] = OP_STORE;
            7: begin
                w[6:0] = OP_IMM;
                if (($urandom() % 2) == 0) begin
                    w[31:25] = (($urandom() % 2) == 0) ? 7'h00 : 7'h20; // Legal shift funct7
                end
            end
            8: w[6:0] = OP_REG;
            default: begin
                do begin
                    w[6:0] = 7'($urandom());
                end while (is_known_opcode(w[6:0]));
            end
        endcase
        return w;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_opcode(input string name, input opcode_t got, input opcode_t want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_index(input string name, input logic [REG_WIDTH-1:0] got,
                               input logic [REG_WIDTH-1:0] want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
            abort_run();
        end
    endtask

    task automatic compare_bundle(input decoded_t want);
        check_word("o_pc", o_pc, want.pc);
        check_opcode("o_opcode", o_opcode, want.opcode);
        check_index("o_rd", o_rd, want.rd[REG_WIDTH-1:0]);
        check_word("o_rs1_data", o_rs1_data, want.rs1_data);
        check_word("o_rs2_data", o_rs2_data, want.rs2_data);
        check_word("o_imm", o_imm, want.imm);
        check_flag("o_is_load", o_is_load, want.is_load);
        check_flag("o_is_alu", o_is_alu, want.is_alu);
    endtask

    // Mirror of what the DUT did at the rising edge just passed
    task automatic model_edge();
        if (!i_rst_n) begin
            fm_valid = 1'b0;
            foreach (model_regs[r]) begin
                model_regs[r] = '0;
            end
            exp_q.delete();
        end else begin
            if (i_flush) begin
                fm_valid = 1'b0;    // Input word is lost and the output entry was checked
            end else if (!i_stall) begin
                if (fm_valid) begin
                    exp_q.push_back(decode_ref(fm_inst, fm_pc, model_regs,
                                               i_wb_en, i_wb_rd, i_wb_data));
                end
                fm_valid = i_inst_valid;
                fm_inst  = i_inst;
                fm_pc    = i_pc;
            end
            if (i_wb_en && i_wb_rd != '0) begin
                model_regs[i_wb_rd] = i_wb_data;    // Writes ignore stall and flush
            end
        end
    endtask

    // Pass one rising edge and land on the falling edge
    task automatic tick();
        @(negedge i_clk);
        model_edge();
    endtask

    task automatic drive_quiet();
        i_inst_valid = 1'b0;
        i_stall      = 1'b0;
        i_flush      = 1'b0;
        i_wb_en      = 1'b0;
    endtask

    task automatic drive_random_wb();
        i_wb_en   = ($urandom() % 2) == 0;
        i_wb_data = $urandom();
        if (fm_valid && ($urandom() % 4) == 0) begin
            i_wb_rd = fm_inst[19:15];   // Hit the word being read
        end else begin
            i_wb_rd = REG_WIDTH'($urandom());
        end
    endtask

    // Strobe one word and retry once if stalled
    task automatic send_inst(input logic [XLEN-1:0] inst, input bit rnd);
        bit held;
        held         = 1'b0;
        i_inst_valid = 1'b1;
        i_inst       = inst;
        i_pc         = next_pc;
        next_pc      = next_pc + 32'd4;
        do begin
            i_stall = rnd && !held && (($urandom() % 5) == 0);
            i_flush = rnd && (($urandom() % 32) == 0);
            if (rnd) begin
                drive_random_wb();
            end else begin
                i_wb_en = 1'b0;
            end
            tick();
            held = 1'b1;
        end while (i_stall && !i_flush);
        drive_quiet();
        if (rnd && ($urandom() % 4) == 0) begin    // Occasional gap
            i_stall = ($urandom() % 4) == 0;
            drive_random_wb();
            tick();
            drive_quiet();
        end
    endtask

    task automatic write_reg(input logic [REG_WIDTH-1:0] rd, input logic [XLEN-1:0] data);
        drive_quiet();
        i_wb_en   = 1'b1;
        i_wb_rd   = rd;
        i_wb_data = data;
        tick();
        i_wb_en   = 1'b0;
    endtask

    task automatic idle(input int n);
        drive_quiet();
        repeat (n) begin
            tick();
        end
    endtask

    task automatic hold_stall(input int n);
        drive_quiet();
        i_stall = 1'b1;
        repeat (n) begin
            tick();
        end
        i_stall = 1'b0;
    endtask

    task automatic pulse_flush();
        drive_quiet();
        i_flush = 1'b1;
        tick();
        i_flush = 1'b0;
    endtask

    task automatic apply_reset();
        drive_quiet();
        i_rst_n = 1'b0;
        repeat (RESET_CYCLES) begin
            tick();
            check_flag("o_valid", o_valid, 1'b0);  // Low all through reset
        end
        i_rst_n = 1'b1;
        tick();
        check_flag("o_valid", o_valid, 1'b0);      // And just after
    endtask

    // Output check that peeks while stalled and pops when the stage moves
    always @(posedge i_clk) begin
        if (o_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output: o_valid high with no instruction in flight");
                abort_run();
            end else begin
                compare_bundle(exp_q[0]);
                if (!i_stall || i_flush || !i_rst_n) begin
                    exp_q.delete(0);
                end
            end
        end else if (exp_q.size() != 0) begin
            $display("Missing output: o_valid low while an instruction is due");
            abort_run();
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
        abort_run();
    end

    initial begin
        seed_ret     = $urandom(RAND_SEED);
        i_rst_n      = 1'b0;
        i_inst_valid = 1'b0;
        i_inst       = '0;
        i_pc         = '0;
        i_stall      = 1'b0;
        i_flush      = 1'b0;
        i_wb_en      = 1'b0;
        i_wb_rd      = '0;
        i_wb_data    = '0;
        fm_valid     = 1'b0;
        fm_inst      = '0;
        fm_pc        = '0;
        next_pc      = 32'h0000_1000;
        foreach (model_regs[r]) begin
            model_regs[r] = '0;
        end
        apply_reset();

        for (int k = 0; k < N_WORDS; k++) begin
            send_inst(DIRECTED_WORDS[k], 1'b0);
        end
        idle(2);

        // Operands from the array then by write-through then from x0
        write_reg(5'd1, 32'h1234_5678);
        write_reg(5'd2, 32'h8000_0001);
        send_inst(32'h002081b3, 1'b0);
        send_inst(32'h002081b3, 1'b0);
        write_reg(5'd1, 32'hcafe_f00d);    // Lands while the second add sits in the input stage
        write_reg(5'd0, 32'hdead_beef);
        send_inst(32'h00000033, 1'b0);     // Reads x0 twice
        idle(2);

        // Two in flight get stalled and then flushed
        send_inst(32'h002081b3, 1'b0);
        send_inst(32'hfff00093, 1'b0);
        hold_stall(3);
        pulse_flush();
        idle(2);

        // Stall then let both drain
        send_inst(32'h800000b7, 1'b0);
        send_inst(32'hfe5ff06f, 1'b0);
        hold_stall(2);
        idle(3);

        repeat (N_BURST) begin
            send_inst(random_inst(), 1'b0);   // One per cycle
        end
        idle(2);

        repeat (N_RANDOM) begin
            send_inst(random_inst(), 1'b1);
        end
        idle(3);

        // Reset in the middle of traffic followed by a short tail
        send_inst(random_inst(), 1'b0);
        apply_reset();
        repeat (N_TAIL) begin
            send_inst(random_inst(), 1'b1);
        end
        idle(4);

        $display("=== PASS ===");
        $finish;
    end

endmodule

//--- sources.f
logic/rv32i_isa_pkg.sv
logic/decode_types_pkg.sv
logic/pipe_stage.sv
logic/rv32i_decoder.sv
logic/reg_file.sv
logic/decode_stage_top.sv
tests/decode_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, a $fatal in the testbench gives a non-zero exit
cd "$(dirname "$0")" \
    && verilator --binary --timing --timescale 1ns/10ps \
        --top-module decode_stage_tb -f sources.f \
        --Mdir obj_dir -o decode_stage_sim \
    && ./obj_dir/decode_stage_sim \
    && echo "Simulation finished cleanly" \
    || { echo "Simulation build or run failed"; exit 1; }
